// File: rtl/spi_params.svh
// SPI master defaults
`ifndef SPI_PARAMS_SVH
`define SPI_PARAMS_SVH

// bus mode defaults, mode 3
`define SPI_CPOL 1'b1 // sclk idle level
`define SPI_CPHA 1'b1 // sample on trailing edge

// sys_clk cycles of cs setup before and hold after the frame
`define SPI_CS_GAP 2

// run-time divider input width
`define SPI_DIV_W 16

// register address width, msb of the address byte is the read flag
`define SPI_ADDR_W 7

`endif

// File: rtl/spi_pkg.sv
// SPI register access types
`default_nettype none
`include "spi_params.svh"

package spi_pkg;

	typedef enum logic {
		OP_WRITE = 1'b0,
		OP_READ  = 1'b1 // goes out as msb of the address byte
	} spi_op_e;

	typedef struct packed {
		spi_op_e                 op;
		logic [`SPI_ADDR_W-1:0]  addr;
		logic [7:0]              wdata;
	} spi_cmd_t;

	typedef struct packed {
		spi_op_e                 op;    // echoed from the command
		logic [`SPI_ADDR_W-1:0]  addr;  // echoed from the command
		logic [7:0]              rdata; // byte seen in the data phase
	} spi_rsp_t;

	typedef struct packed {
		logic cs;   // active low
		logic sclk;
		logic mosi;
	} spi_bus_t;

	// byte engine
	typedef enum logic [2:0] {
		BYTE_IDLE      = 3'd0,
		BYTE_HALF_WAIT = 3'd1, // count out half an sclk period
		BYTE_EDGE      = 3'd2, // one sclk edge
		BYTE_LAST_HALF = 3'd3, // trailing half after edge 16
		BYTE_ACK       = 3'd4,
		BYTE_FINISH    = 3'd5
	} spi_byte_state_e;

	// transaction sequencer
	typedef enum logic [3:0] {
		SEQ_IDLE      = 4'd0,
		SEQ_CS_SETUP  = 4'd1,
		SEQ_ADDR      = 4'd2,
		SEQ_ADDR_WAIT = 4'd3,
		SEQ_GAP       = 4'd4,
		SEQ_DATA      = 4'd5,
		SEQ_DATA_WAIT = 4'd6,
		SEQ_CS_HOLD   = 4'd7,
		SEQ_RESP      = 4'd8
	} spi_seq_state_e;

endpackage

`default_nettype wire

// File: rtl/spi_master.sv
// SPI byte engine
`default_nettype none
`include "spi_params.svh"

module spi_master #(
	parameter logic CPOL = `SPI_CPOL, // sclk idle level
	parameter logic CPHA = `SPI_CPHA  // 0 samples on leading edge, 1 on trailing
) (
	input  wire                    sys_clk,
	input  wire                    sys_rst_n,

	input  wire                    cs_ctrl,  // passed straight to the bus
	input  wire [`SPI_DIV_W-1:0]   clk_div,  // half period is clk_div+2 cycles

	input  wire                    wr_req,   // sampled in BYTE_IDLE only
	output logic                   wr_ack,   // one cycle, byte done

	input  wire [7:0]              data_tx,
	output logic [7:0]             data_rx,  // valid from wr_ack onward

	input  wire                    miso,
	output spi_pkg::spi_bus_t      bus
);

	localparam int CNT_W = `SPI_DIV_W + 1; // room for clk_div+1 in the last half

	spi_pkg::spi_byte_state_e state;

	logic [CNT_W-1:0] cnt_clk;      // cycles within the current half period
	logic [3:0]       edge_cnt;     // sclk edges done, 0..15
	logic             sclk;
	logic [7:0]       mosi_shift;
	logic [7:0]       miso_shift;

	logic             at_edge;
	logic             half_done;
	logic             last_done;
	logic             launch_edge;
	logic             capture_edge;

	assign at_edge   = (state == spi_pkg::BYTE_EDGE);
	assign half_done = (cnt_clk == {1'b0, clk_div});
	assign last_done = (cnt_clk == {1'b0, clk_div} + CNT_W'(1)); // full half incl. edge slot

	// mode 0/2 launches on odd edges, mode 1/3 on even edges after the first
	assign launch_edge  = at_edge && (CPHA ? (edge_cnt != 4'd0 && !edge_cnt[0])
	                                       : edge_cnt[0]);
	assign capture_edge = at_edge && (CPHA ? edge_cnt[0] : !edge_cnt[0]);

	assign wr_ack  = (state == spi_pkg::BYTE_ACK);
	assign data_rx = miso_shift;
	assign bus     = '{cs: cs_ctrl, sclk: sclk, mosi: mosi_shift[7]};

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			state <= spi_pkg::BYTE_IDLE;
		end else begin
			case (state)
				spi_pkg::BYTE_IDLE: begin
					if (wr_req)
						state <= spi_pkg::BYTE_HALF_WAIT;
				end
				spi_pkg::BYTE_HALF_WAIT: begin
					if (half_done)
						state <= spi_pkg::BYTE_EDGE;
				end
				spi_pkg::BYTE_EDGE: begin
					if (edge_cnt == 4'd15)
						state <= spi_pkg::BYTE_LAST_HALF; // 16th edge just issued
					else
						state <= spi_pkg::BYTE_HALF_WAIT;
				end
				spi_pkg::BYTE_LAST_HALF: begin
					if (last_done)
						state <= spi_pkg::BYTE_ACK;
				end
				spi_pkg::BYTE_ACK: begin
					state <= spi_pkg::BYTE_FINISH;
				end
				spi_pkg::BYTE_FINISH: begin
					state <= spi_pkg::BYTE_IDLE;
				end
				default: begin
					state <= spi_pkg::BYTE_IDLE;
				end
			endcase
		end
	end

	// half period counter, runs only while waiting
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n)
			cnt_clk <= '0;
		else if (state == spi_pkg::BYTE_HALF_WAIT || state == spi_pkg::BYTE_LAST_HALF)
			cnt_clk <= cnt_clk + CNT_W'(1);
		else
			cnt_clk <= '0;
	end

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n)
			edge_cnt <= 4'd0;
		else if (state == spi_pkg::BYTE_IDLE)
			edge_cnt <= 4'd0;
		else if (at_edge)
			edge_cnt <= edge_cnt + 4'd1; // wraps after edge 16
	end

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n)
			sclk <= CPOL;
		else if (state == spi_pkg::BYTE_IDLE)
			sclk <= CPOL;
		else if (at_edge)
			sclk <= ~sclk; // 16 toggles end back at CPOL
	end

	// msb first, rotated so bit 7 always drives mosi
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n)
			mosi_shift <= 8'h00;
		else if (state == spi_pkg::BYTE_IDLE && wr_req)
			mosi_shift <= data_tx;
		else if (launch_edge)
			mosi_shift <= {mosi_shift[6:0], mosi_shift[7]};
	end

	always_ff @(posedge sys_clk) begin
		if (capture_edge)
			miso_shift <= {miso_shift[6:0], miso}; // eight captures per byte
	end

endmodule

`default_nettype wire

// File: rtl/spi_seq.sv
// SPI register transaction sequencer
`default_nettype none
`include "spi_params.svh"

module spi_seq (
	input  wire                 sys_clk,
	input  wire                 sys_rst_n,

	input  wire                 cmd_valid, // one-cycle strobe
	input  wire spi_pkg::spi_cmd_t cmd,
	output logic                busy,
	output logic                rsp_valid, // one-cycle pulse per command
	output spi_pkg::spi_rsp_t   rsp,

	output logic                cs_ctrl,   // active low
	output logic                wr_req,
	input  wire                 wr_ack,
	output logic [7:0]          data_tx,
	input  wire [7:0]           data_rx
);

	localparam int GAP_W = $clog2(`SPI_CS_GAP + 1);

	spi_pkg::spi_seq_state_e state;
	spi_pkg::spi_cmd_t       cmd_q;     // command under way
	logic [7:0]              rdata_q;
	logic [GAP_W-1:0]        gap_cnt;   // cs setup and hold counter

	logic                    accept;
	logic                    gap_done;
	logic [7:0]              addr_byte;
	logic [7:0]              data_byte;

	assign accept   = cmd_valid && (state == spi_pkg::SEQ_IDLE); // dropped while busy
	assign gap_done = (gap_cnt == GAP_W'(`SPI_CS_GAP - 1));

	assign busy      = (state != spi_pkg::SEQ_IDLE);
	assign rsp_valid = (state == spi_pkg::SEQ_RESP);
	assign wr_req    = (state == spi_pkg::SEQ_ADDR) || (state == spi_pkg::SEQ_DATA);

	// read flag in the msb, then the address
	assign addr_byte = {cmd_q.op, cmd_q.addr};
	assign data_byte = (cmd_q.op == spi_pkg::OP_READ) ? 8'h00 : cmd_q.wdata; // dummy on reads
	assign data_tx   = (state == spi_pkg::SEQ_ADDR) ? addr_byte : data_byte;

	assign rsp = '{op: cmd_q.op, addr: cmd_q.addr, rdata: rdata_q};

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			state <= spi_pkg::SEQ_IDLE;
		end else begin
			case (state)
				spi_pkg::SEQ_IDLE: begin
					if (accept)
						state <= spi_pkg::SEQ_CS_SETUP;
				end
				spi_pkg::SEQ_CS_SETUP: begin
					if (gap_done)
						state <= spi_pkg::SEQ_ADDR;
				end
				spi_pkg::SEQ_ADDR: begin
					state <= spi_pkg::SEQ_ADDR_WAIT;
				end
				spi_pkg::SEQ_ADDR_WAIT: begin
					if (wr_ack)
						state <= spi_pkg::SEQ_GAP;
				end
				spi_pkg::SEQ_GAP: begin
					state <= spi_pkg::SEQ_DATA; // engine sits in BYTE_FINISH here
				end
				spi_pkg::SEQ_DATA: begin
					state <= spi_pkg::SEQ_DATA_WAIT;
				end
				spi_pkg::SEQ_DATA_WAIT: begin
					if (wr_ack)
						state <= spi_pkg::SEQ_CS_HOLD;
				end
				spi_pkg::SEQ_CS_HOLD: begin
					if (gap_done)
						state <= spi_pkg::SEQ_RESP;
				end
				spi_pkg::SEQ_RESP: begin
					state <= spi_pkg::SEQ_IDLE;
				end
				default: begin
					state <= spi_pkg::SEQ_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n)
			gap_cnt <= '0;
		else if ((state == spi_pkg::SEQ_CS_SETUP || state == spi_pkg::SEQ_CS_HOLD)
		         && !gap_done)
			gap_cnt <= gap_cnt + GAP_W'(1);
		else
			gap_cnt <= '0;
	end

	// registered so cs never glitches on state changes
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n)
			cs_ctrl <= 1'b1;
		else if (accept)
			cs_ctrl <= 1'b0; // falls as busy rises
		else if (state == spi_pkg::SEQ_CS_HOLD && gap_done)
			cs_ctrl <= 1'b1; // high again during SEQ_RESP
	end

	always_ff @(posedge sys_clk) begin
		if (accept)
			cmd_q <= cmd;
	end

	always_ff @(posedge sys_clk) begin
		if (state == spi_pkg::SEQ_DATA_WAIT && wr_ack)
			rdata_q <= data_rx; // data phase byte
	end

endmodule

`default_nettype wire

// File: rtl/spi_top.sv
// SPI register master top
`default_nettype none
`include "spi_params.svh"

module spi_top (
	input  wire                    sys_clk,
	input  wire                    sys_rst_n,

	input  wire [`SPI_DIV_W-1:0]   div,       // keep steady while busy
	input  wire                    cmd_valid,
	input  wire spi_pkg::spi_cmd_t cmd,
	output logic                   busy,
	output logic                   rsp_valid,
	output spi_pkg::spi_rsp_t      rsp,

	output spi_pkg::spi_bus_t      spi_out,
	input  wire                    miso
);

	logic       cs_ctrl;
	logic       wr_req;
	logic       wr_ack;
	logic [7:0] data_tx;
	logic [7:0] data_rx;

	spi_seq u_seq (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.cmd_valid (cmd_valid),
		.cmd       (cmd),
		.busy      (busy),
		.rsp_valid (rsp_valid),
		.rsp       (rsp),
		.cs_ctrl   (cs_ctrl),
		.wr_req    (wr_req),
		.wr_ack    (wr_ack),
		.data_tx   (data_tx),
		.data_rx   (data_rx)
	);

	spi_master #(
		.CPOL (`SPI_CPOL),
		.CPHA (`SPI_CPHA)
	) u_master (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.cs_ctrl   (cs_ctrl),
		.clk_div   (div),
		.wr_req    (wr_req),
		.wr_ack    (wr_ack),
		.data_tx   (data_tx),
		.data_rx   (data_rx),
		.miso      (miso),
		.bus       (spi_out)
	);

endmodule

`default_nettype wire

// File: verification/spi_slave_model.sv
// SPI register slave model
`default_nettype none
`include "spi_params.svh"

module spi_slave_model #(
	parameter logic CPOL = `SPI_CPOL,
	parameter logic CPHA = `SPI_CPHA
) (
	input  wire  cs_n,
	input  wire  sclk,
	input  wire  mosi,
	output logic miso
);

	logic [7:0] regs [0:127];
	logic [7:0] hdr;      // read flag and address of the current frame
	logic [7:0] rx_byte;
	int         n_bits;   // bits sampled in this frame
	logic       prev_cs;
	logic       prev_sclk;

	initial begin
		for (int i = 0; i < 128; i++)
			regs[i] = 8'(i) ^ 8'hA5; // reset contents
		hdr       = 8'h00;
		rx_byte   = 8'h00;
		n_bits    = 0;
		prev_cs   = 1'b1;
		prev_sclk = CPOL;
	end

	// sample edge is the leading edge for CPHA 0, the trailing edge for CPHA 1
	always @(sclk or cs_n) begin
		if (cs_n !== prev_cs) begin
			if (cs_n === 1'b0) begin
				n_bits = 0; // new frame
			end else if (cs_n === 1'b1 && n_bits == 16 && !hdr[7]) begin
				regs[hdr[6:0]] = rx_byte; // write lands at end of frame
			end
			prev_cs = cs_n;
		end else if (cs_n === 1'b0 && sclk !== prev_sclk
		             && ((sclk != CPOL) != CPHA) && n_bits < 16) begin
			rx_byte = {rx_byte[6:0], mosi};
			n_bits  = n_bits + 1;
			if (n_bits == 8)
				hdr = rx_byte;
		end
		prev_sclk = sclk;
	end

	// next bit to be sampled, zero outside the data byte of a read
	always_comb begin
		if (n_bits >= 8 && n_bits < 16 && hdr[7])
			miso = regs[hdr[6:0]][3'(15 - n_bits)];
		else
			miso = 1'b0;
	end

endmodule

`default_nettype wire

// File: verification/spi_assert.sv
// SPI protocol assertions
`default_nettype none
`include "spi_params.svh"

module spi_assert (
	input wire               sys_clk,
	input wire               sys_rst_n,
	input spi_pkg::spi_bus_t spi_out,
	input wire               wr_req,
	input wire               wr_ack,
	input wire               busy,
	input wire               rsp_valid
);

	ack_one_cycle: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		wr_ack |=> !wr_ack)
		else $error("wr_ack held longer than one cycle");

	// no clocking while deselected
	sclk_quiet_cs_high: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		(spi_out.cs && $past(spi_out.cs)) |-> $stable(spi_out.sclk))
		else $error("sclk moved while cs was high");

	req_under_cs: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		wr_req |-> !spi_out.cs)
		else $error("wr_req fired with cs high");

	rsp_while_busy: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		rsp_valid |-> busy)
		else $error("rsp_valid outside of busy");

endmodule

bind spi_top spi_assert u_assert (
	.sys_clk   (sys_clk),
	.sys_rst_n (sys_rst_n),
	.spi_out   (spi_out),
	.wr_req    (wr_req),
	.wr_ack    (wr_ack),
	.busy      (busy),
	.rsp_valid (rsp_valid)
);

`default_nettype wire

// File: verification/spi_tb.sv
// SPI register master testbench
`default_nettype none
`include "spi_params.svh"

module spi_tb;

	localparam int MAX_CYCLES = 100000; // ~200 commands at ~300 cycles, with margin

	logic                  sys_clk;
	logic                  sys_rst_n;
	logic [`SPI_DIV_W-1:0] div;
	logic                  cmd_valid;
	spi_pkg::spi_cmd_t     cmd;
	logic                  busy;
	logic                  rsp_valid;
	spi_pkg::spi_rsp_t     rsp;
	spi_pkg::spi_bus_t     spi_out;
	logic                  miso;

	logic [7:0]        shadow [0:127];
	logic [127:0]      written;  // registers reached by a write
	spi_pkg::spi_rsp_t exp_q [$];
	int                cycles = 0;

	initial begin
		sys_clk = 1'b0;
		forever #5 sys_clk = ~sys_clk;
	end

	spi_top u_dut (
		.sys_clk (sys_clk), .sys_rst_n (sys_rst_n), .div (div),
		.cmd_valid (cmd_valid), .cmd (cmd), .busy (busy),
		.rsp_valid (rsp_valid), .rsp (rsp), .spi_out (spi_out), .miso (miso)
	);

	spi_slave_model #(.CPOL (`SPI_CPOL), .CPHA (`SPI_CPHA)) u_slave (
		.cs_n (spi_out.cs), .sclk (spi_out.sclk), .mosi (spi_out.mosi), .miso (miso)
	);

	// shadow register file, same reset rule as the slave
	function automatic spi_pkg::spi_rsp_t expected_rsp(input spi_pkg::spi_cmd_t c);
		spi_pkg::spi_rsp_t r;
		r.op   = c.op;
		r.addr = c.addr;
		r.rdata = 8'h00;
		if (c.op == spi_pkg::OP_READ) begin
			r.rdata = shadow[c.addr];
		end else begin
			shadow[c.addr]  = c.wdata;
			written[c.addr] = 1'b1;
		end
		return r;
	endfunction

	function automatic spi_pkg::spi_cmd_t random_cmd();
		spi_pkg::spi_cmd_t c;
		c.op    = spi_pkg::spi_op_e'(1'($urandom_range(0, 1)));
		c.addr  = 7'($urandom_range(0, 127));
		c.wdata = 8'($urandom);
		return c;
	endfunction

	task automatic stop_with_error(input string what);
		$display("%s", what);
		$display("RESULT: FAIL");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp)
			stop_with_error($sformatf("MISMATCH time %0t %s got %02h expected %02h",
			                          $time, name, got, exp));
	endtask

	// waits for idle, then strobes one accepted command
	task automatic send_cmd(input spi_pkg::spi_cmd_t c);
		while (busy) begin
			@(posedge sys_clk);
			#1;
		end
		cmd       = c;
		cmd_valid = 1'b1;
		exp_q.push_back(expected_rsp(c));
		@(posedge sys_clk);
		#1;
		cmd_valid = 1'b0;
	endtask

	// write to the frame's address during the frame, must be dropped
	task automatic strobe_while_busy(input spi_pkg::spi_cmd_t c);
		int wait_n;
		wait_n = $urandom_range(0, 20);
		repeat (wait_n) begin
			@(posedge sys_clk);
			#1;
		end
		if (busy) begin
			cmd       = c;
			cmd.op    = spi_pkg::OP_WRITE;
			cmd.wdata = ~c.wdata;
			cmd_valid = 1'b1;
			@(posedge sys_clk);
			#1;
			cmd_valid = 1'b0;
		end
	endtask

	// reads of registers that no write has reached yet
	task automatic read_untouched(input int n);
		spi_pkg::spi_cmd_t c;
		for (int i = 0; i < n; i++) begin
			c = random_cmd();
			c.op = spi_pkg::OP_READ;
			while (written[c.addr])
				c.addr = c.addr + 7'd1;
			send_cmd(c);
		end
	endtask

	task automatic run_block(input logic [`SPI_DIV_W-1:0] d);
		spi_pkg::spi_cmd_t c;
		while (busy) begin
			@(posedge sys_clk);
			#1;
		end
		div = d;
		read_untouched(8);
		for (int i = 0; i < 20; i++) begin
			c = random_cmd();
			c.op = spi_pkg::OP_WRITE;
			send_cmd(c);
			strobe_while_busy(c);
			c.op = spi_pkg::OP_READ; // read back the same address
			send_cmd(c);
		end
		for (int i = 0; i < 10; i++)
			send_cmd(random_cmd());
	endtask

	// compare on the falling edge, away from DUT updates
	always @(negedge sys_clk) begin
		spi_pkg::spi_rsp_t e;
		if (sys_rst_n === 1'b1 && rsp_valid === 1'b1) begin
			if (exp_q.size() == 0) begin
				stop_with_error("response arrived with no command outstanding");
			end else begin
				e = exp_q.pop_front();
				check_value("rsp.op", 8'(rsp.op), 8'(e.op));
				check_value("rsp.addr", 8'(rsp.addr), 8'(e.addr));
				if (e.op == spi_pkg::OP_READ)
					check_value("rsp.rdata", rsp.rdata, e.rdata);
			end
		end
	end

	always @(posedge sys_clk) begin
		cycles++;
		if (cycles >= MAX_CYCLES)
			stop_with_error("timeout, run exceeded the cycle limit");
	end

	initial begin
		void'($urandom(94823));
		for (int i = 0; i < 128; i++)
			shadow[i] = 8'(i) ^ 8'hA5;
		written   = '0;
		sys_rst_n = 1'b0;
		cmd_valid = 1'b0;
		cmd       = '0;
		div       = '0;
		repeat (4) @(posedge sys_clk);
		#1;
		sys_rst_n = 1'b1;
		@(posedge sys_clk);
		#1;
		check_value("spi_out.cs", 8'(spi_out.cs), 8'd1);
		check_value("spi_out.sclk", 8'(spi_out.sclk), 8'(`SPI_CPOL));
		check_value("busy", 8'(busy), 8'd0);
		check_value("rsp_valid", 8'(rsp_valid), 8'd0);
		run_block(16'd0);
		run_block(16'd1);
		run_block(16'd5);
		while (busy || exp_q.size() != 0) begin
			@(posedge sys_clk);
			#1;
		end
		$display("RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// File: sim.f
+incdir+rtl
rtl/spi_pkg.sv
rtl/spi_master.sv
rtl/spi_seq.sv
rtl/spi_top.sv
verification/spi_slave_model.sv
verification/spi_assert.sv
verification/spi_tb.sv

// File: run.sh
#!/bin/sh
# build and run the SPI master simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f sim.f \
	--top-module spi_tb \
	-o spi_tb_sim

./obj_dir/spi_tb_sim
